//--- source/fc_lcc_svc_pkg.sv
// fuse controller / lifecycle controller test service package
// service opcodes, override encodings, fault addresses and hold length
// shared by the command decoder, the pulser, the clock requester and the top

package fc_lcc_svc_pkg;

  // ----------------------------------------------------------------------
  // service command opcodes
  // ----------------------------------------------------------------------
  typedef enum logic [7:0] {
    // axi user override on the fuse controller write port
    FORCE_AWUSER_CORE = 8'h01,
    FORCE_AWUSER_MCU  = 8'h02,
    RELEASE_AWUSER    = 8'h03,
    // zeroization override group
    ZEROIZE_SET       = 8'h04,
    ZEROIZE_CLEAR     = 8'h05,
    RELEASE_ZEROIZE   = 8'h06,
    // escalation triggers
    FC_ESCALATE       = 8'h07,
    LC_ESC0_SET       = 8'h08,
    LC_ESC1_SET       = 8'h09,
    LC_ESC0_REL       = 8'h0a,
    LC_ESC1_REL       = 8'h0b,
    // fuse/lifecycle sub-reset pulse
    FC_LCC_RESET      = 8'h10,
    // external clock frequency requests
    CLK_160           = 8'h11,
    CLK_400           = 8'h12,
    CLK_500           = 8'h13,
    CLK_1000          = 8'h14,
    // write data corruption enables, sticky until reset
    FC_BUS_FAULT      = 8'h15,
    LCC_BUS_FAULT     = 8'h16,
    // lifecycle assertion control
    SVA_DISABLE       = 8'h17,
    SVA_ENABLE        = 8'h18
  } svc_cmd_e;

  // ----------------------------------------------------------------------
  // override encodings
  // ----------------------------------------------------------------------
  // awuser source picked by the override, none means no override
  typedef enum logic [1:0] {
    AWUSER_NONE = 2'd0,
    AWUSER_CORE = 2'd1,
    AWUSER_MCU  = 2'd2
  } awuser_sel_e;

  // on: zeroize asserted, rom mask all ones, scrap cleared
  // off: zeroize low, rom mask zero, scrap set
  typedef enum logic [1:0] {
    ZEROIZE_NONE = 2'd0,
    ZEROIZE_ON   = 2'd1,
    ZEROIZE_OFF  = 2'd2
  } zeroize_ovr_e;

  // requested external clock frequency
  typedef enum logic [1:0] {
    CLK_F160  = 2'd0,
    CLK_F400  = 2'd1,
    CLK_F500  = 2'd2,
    CLK_F1000 = 2'd3
  } clk_freq_e;

  // ----------------------------------------------------------------------
  // constants
  // ----------------------------------------------------------------------
  // fuse controller access-port write register
  localparam logic [31:0] FC_FAULT_ADDR  = 32'h7000_0068;
  // lifecycle transition register
  localparam logic [31:0] LCC_FAULT_ADDR = 32'h7000_0400;
  // sub-reset low time in clk cycles
  localparam int unsigned RST_HOLD_CYCLES = 11;

endpackage

//--- source/svc_override_regs.sv
// service override register block
// decodes the service command strobe into registered override levels
// and the sticky bus fault enables for both write ports

module svc_override_regs (
  input  logic                         clk,
  input  logic                         cptra_rst_b,
  input  logic                         svc_cmd_valid_i,
  input  fc_lcc_svc_pkg::svc_cmd_e     svc_cmd_i,
  output fc_lcc_svc_pkg::awuser_sel_e  awuser_sel_o,
  output fc_lcc_svc_pkg::zeroize_ovr_e zeroize_ovr_o,
  output logic                         fc_esc_o,
  output logic                         lc_esc0_o,
  output logic                         lc_esc1_o,
  output logic                         sva_disable_o,
  output logic                         fc_bus_fault_en_o,
  output logic                         lcc_bus_fault_en_o
);

  import fc_lcc_svc_pkg::*;

  // override state
  awuser_sel_e  awuser_sel_q;
  zeroize_ovr_e zeroize_ovr_q;
  logic         fc_esc_q;
  logic         lc_esc0_q;
  logic         lc_esc1_q;
  logic         sva_disable_q;
  logic         fc_bus_fault_en_q;
  logic         lcc_bus_fault_en_q;

  // ----------------------------------------------------------------------
  // command decode
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      awuser_sel_q       <= AWUSER_NONE;
      zeroize_ovr_q      <= ZEROIZE_NONE;
      fc_esc_q           <= 1'b0;
      lc_esc0_q          <= 1'b0;
      lc_esc1_q          <= 1'b0;
      sva_disable_q      <= 1'b0;
      fc_bus_fault_en_q  <= 1'b0;
      lcc_bus_fault_en_q <= 1'b0;
    end else if (svc_cmd_valid_i) begin
      case (svc_cmd_i)
        // awuser source override
        FORCE_AWUSER_CORE: begin
          awuser_sel_q <= AWUSER_CORE;
        end
        FORCE_AWUSER_MCU: begin
          awuser_sel_q <= AWUSER_MCU;
        end
        RELEASE_AWUSER: begin
          awuser_sel_q <= AWUSER_NONE;
        end
        // zeroization group moves as one
        ZEROIZE_SET: begin
          zeroize_ovr_q <= ZEROIZE_ON;
        end
        ZEROIZE_CLEAR: begin
          zeroize_ovr_q <= ZEROIZE_OFF;
        end
        RELEASE_ZEROIZE: begin
          zeroize_ovr_q <= ZEROIZE_NONE;
        end
        // fuse controller escalation has no release
        FC_ESCALATE: begin
          fc_esc_q <= 1'b1;
        end
        // lifecycle scrap escalations
        LC_ESC0_SET: begin
          lc_esc0_q <= 1'b1;
        end
        LC_ESC1_SET: begin
          lc_esc1_q <= 1'b1;
        end
        LC_ESC0_REL: begin
          lc_esc0_q <= 1'b0;
        end
        LC_ESC1_REL: begin
          lc_esc1_q <= 1'b0;
        end
        // bus faults stay armed until reset
        FC_BUS_FAULT: begin
          fc_bus_fault_en_q <= 1'b1;
        end
        LCC_BUS_FAULT: begin
          lcc_bus_fault_en_q <= 1'b1;
        end
        // lifecycle assertion gate
        SVA_DISABLE: begin
          sva_disable_q <= 1'b1;
        end
        SVA_ENABLE: begin
          sva_disable_q <= 1'b0;
        end
        default: begin
          // clock and reset opcodes belong to other blocks
        end
      endcase
    end
  end

  // outputs straight from the registers
  assign awuser_sel_o       = awuser_sel_q;
  assign zeroize_ovr_o      = zeroize_ovr_q;
  assign fc_esc_o           = fc_esc_q;
  assign lc_esc0_o          = lc_esc0_q;
  assign lc_esc1_o          = lc_esc1_q;
  assign sva_disable_o      = sva_disable_q;
  assign fc_bus_fault_en_o  = fc_bus_fault_en_q;
  assign lcc_bus_fault_en_o = lcc_bus_fault_en_q;

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  // awuser never takes the unused encoding
  a_awuser_legal: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    awuser_sel_q inside {AWUSER_NONE, AWUSER_CORE, AWUSER_MCU}
  ) else $error("awuser_sel_o holds undefined encoding %0h", awuser_sel_q);

endmodule

//--- source/svc_reset_pulser.sv
// fuse/lifecycle sub-reset pulser
// holds the sub-reset low for a fixed number of cycles after a reset command

module svc_reset_pulser (
  input  logic                     clk,
  input  logic                     cptra_rst_b,
  input  logic                     svc_cmd_valid_i,
  input  fc_lcc_svc_pkg::svc_cmd_e svc_cmd_i,
  output logic                     sub_rst_b_o
);

  import fc_lcc_svc_pkg::*;

  // last counter value of the hold window
  localparam logic [3:0] HOLD_LAST = 4'(RST_HOLD_CYCLES - 1);

  logic       busy_q;
  logic [3:0] cnt_q;
  logic       start;

  // a new command only counts while idle
  assign start = svc_cmd_valid_i && (svc_cmd_i == FC_LCC_RESET) && !busy_q;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      if (cnt_q == HOLD_LAST) begin
        // window done, back to idle
        busy_q <= 1'b0;
        cnt_q  <= '0;
      end else begin
        cnt_q <= cnt_q + 4'd1;
      end
    end
  end

  // active low, low while busy
  assign sub_rst_b_o = ~busy_q;

  // counter stays inside the hold window
  a_cnt_range: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    cnt_q <= HOLD_LAST
  ) else $error("reset hold counter out of range %0h", cnt_q);

  // once started the hold lasts exactly RST_HOLD_CYCLES cycles
  a_hold_len: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    $rose(busy_q) |-> busy_q [*RST_HOLD_CYCLES] ##1 !busy_q
  ) else $error("sub-reset hold length wrong");

endmodule

//--- source/svc_clk_req.sv
// external clock request
// keeps the requested frequency and raises a switch request that is
// gated by the bypass ack and drops once the switch has been seen

module svc_clk_req (
  input  logic                      clk,
  input  logic                      cptra_rst_b,
  input  logic                      svc_cmd_valid_i,
  input  fc_lcc_svc_pkg::svc_cmd_e  svc_cmd_i,
  input  logic                      clk_byp_ack_i,
  output fc_lcc_svc_pkg::clk_freq_e clk_sel_o,
  output logic                      clk_switch_req_o
);

  import fc_lcc_svc_pkg::*;

  clk_freq_e clk_sel_q;
  logic      ext_req_q;
  // decoded clock command
  logic      clk_cmd_hit;
  clk_freq_e clk_cmd_freq;

  // ----------------------------------------------------------------------
  // opcode to frequency
  // ----------------------------------------------------------------------
  always_comb begin
    clk_cmd_hit  = 1'b0;
    clk_cmd_freq = clk_sel_q;
    if (svc_cmd_valid_i) begin
      case (svc_cmd_i)
        CLK_160: begin
          clk_cmd_hit  = 1'b1;
          clk_cmd_freq = CLK_F160;
        end
        CLK_400: begin
          clk_cmd_hit  = 1'b1;
          clk_cmd_freq = CLK_F400;
        end
        CLK_500: begin
          clk_cmd_hit  = 1'b1;
          clk_cmd_freq = CLK_F500;
        end
        CLK_1000: begin
          clk_cmd_hit  = 1'b1;
          clk_cmd_freq = CLK_F1000;
        end
        default: begin
          // not a clock opcode
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // request register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      clk_sel_q <= CLK_F1000;
      ext_req_q <= 1'b0;
    end else if (clk_cmd_hit) begin
      // new command beats the clear
      clk_sel_q <= clk_cmd_freq;
      ext_req_q <= 1'b1;
    end else if (clk_switch_req_o) begin
      ext_req_q <= 1'b0;
    end
  end

  assign clk_sel_o        = clk_sel_q;
  assign clk_switch_req_o = ext_req_q & clk_byp_ack_i;

  // switch request needs the ack
  a_switch_needs_ack: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    clk_switch_req_o |-> clk_byp_ack_i
  ) else $error("clk_switch_req_o high without clk_byp_ack_i");

endmodule

//--- source/svc_bus_fault.sv
// write data bit-0 corruptor
// clears bit 0 of outgoing write data when armed and the write hits the
// target register, everything else passes through untouched

module svc_bus_fault #(
  parameter logic [31:0] TARGET_ADDR = 32'h0
) (
  input  logic        fault_en_i,
  input  logic        wr_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] wdata_o
);

  // write that lands on the target while armed
  logic addr_match;
  logic fault_hit;

  assign addr_match = (addr_i == TARGET_ADDR);
  assign fault_hit  = fault_en_i & wr_i & addr_match;

  // upper bits always pass
  // bit 0 forced low on a hit, reads keep their data
  assign wdata_o = {wdata_i[31:1], wdata_i[0] & ~fault_hit};

endmodule

//--- source/fc_lcc_svc_top.sv
// fuse controller / lifecycle controller test service top
// override registers, sub-reset pulser, clock requester and the two
// write data corruptors, all fed by the same command strobe

module fc_lcc_svc_top (
  input  logic                         clk,
  input  logic                         cptra_rst_b,
  // service command
  input  logic                         svc_cmd_valid_i,
  input  fc_lcc_svc_pkg::svc_cmd_e     svc_cmd_i,
  input  logic                         clk_byp_ack_i,
  // fuse controller write port
  input  logic                         fc_wr_i,
  input  logic [31:0]                  fc_addr_i,
  input  logic [31:0]                  fc_wdata_i,
  output logic [31:0]                  fc_wdata_o,
  // lifecycle controller write port
  input  logic                         lcc_wr_i,
  input  logic [31:0]                  lcc_addr_i,
  input  logic [31:0]                  lcc_wdata_i,
  output logic [31:0]                  lcc_wdata_o,
  // override levels
  output fc_lcc_svc_pkg::awuser_sel_e  awuser_sel_o,
  output fc_lcc_svc_pkg::zeroize_ovr_e zeroize_ovr_o,
  output logic                         fc_esc_o,
  output logic                         lc_esc0_o,
  output logic                         lc_esc1_o,
  output logic                         sva_disable_o,
  // sub-reset and clock control
  output logic                         sub_rst_b_o,
  output fc_lcc_svc_pkg::clk_freq_e    clk_sel_o,
  output logic                         clk_switch_req_o
);

  import fc_lcc_svc_pkg::*;

  // fault arming from the register block
  logic fc_bus_fault_en;
  logic lcc_bus_fault_en;

  // ----------------------------------------------------------------------
  // command consumers
  // ----------------------------------------------------------------------
  svc_override_regs u_override_regs (
    .clk                (clk),
    .cptra_rst_b        (cptra_rst_b),
    .svc_cmd_valid_i    (svc_cmd_valid_i),
    .svc_cmd_i          (svc_cmd_i),
    .awuser_sel_o       (awuser_sel_o),
    .zeroize_ovr_o      (zeroize_ovr_o),
    .fc_esc_o           (fc_esc_o),
    .lc_esc0_o          (lc_esc0_o),
    .lc_esc1_o          (lc_esc1_o),
    .sva_disable_o      (sva_disable_o),
    .fc_bus_fault_en_o  (fc_bus_fault_en),
    .lcc_bus_fault_en_o (lcc_bus_fault_en)
  );

  svc_reset_pulser u_reset_pulser (
    .clk             (clk),
    .cptra_rst_b     (cptra_rst_b),
    .svc_cmd_valid_i (svc_cmd_valid_i),
    .svc_cmd_i       (svc_cmd_i),
    .sub_rst_b_o     (sub_rst_b_o)
  );

  svc_clk_req u_clk_req (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .svc_cmd_valid_i  (svc_cmd_valid_i),
    .svc_cmd_i        (svc_cmd_i),
    .clk_byp_ack_i    (clk_byp_ack_i),
    .clk_sel_o        (clk_sel_o),
    .clk_switch_req_o (clk_switch_req_o)
  );

  // ----------------------------------------------------------------------
  // write data corruptors
  // ----------------------------------------------------------------------
  // fuse controller dai write register
  svc_bus_fault #(
    .TARGET_ADDR (FC_FAULT_ADDR)
  ) u_fc_bus_fault (
    .fault_en_i (fc_bus_fault_en),
    .wr_i       (fc_wr_i),
    .addr_i     (fc_addr_i),
    .wdata_i    (fc_wdata_i),
    .wdata_o    (fc_wdata_o)
  );

  // lifecycle transition register
  svc_bus_fault #(
    .TARGET_ADDR (LCC_FAULT_ADDR)
  ) u_lcc_bus_fault (
    .fault_en_i (lcc_bus_fault_en),
    .wr_i       (lcc_wr_i),
    .addr_i     (lcc_addr_i),
    .wdata_i    (lcc_wdata_i),
    .wdata_o    (lcc_wdata_o)
  );

endmodule

//--- testbench/tb_fc_lcc_svc.sv
// testbench for the fuse/lifecycle test service controller
// a table of commands and bus traffic is applied in a loop
// results are checked one cycle after each command

module tb_fc_lcc_svc;

  import fc_lcc_svc_pkg::*;

  // stim bits {valid, ack, fc_wr, fc_hit, lcc_wr, lcc_hit}
  // expected bits {fc_esc, lc_esc0, lc_esc1, sva_dis, sub_rst_b, switch, fc_clr, lcc_clr}
  typedef struct packed {
    svc_cmd_e     cmd;
    logic [5:0]   stim;
    awuser_sel_e  awuser;
    zeroize_ovr_e zeroize;
    logic [7:0]   bits;
    clk_freq_e    freq;
  } row_t;

  logic         clk;
  logic         cptra_rst_b;
  logic         svc_cmd_valid;
  svc_cmd_e     svc_cmd;
  logic         clk_byp_ack;
  logic         fc_wr;
  logic [31:0]  fc_addr;
  logic [31:0]  fc_wdata;
  logic [31:0]  fc_wdata_out;
  logic         lcc_wr;
  logic [31:0]  lcc_addr;
  logic [31:0]  lcc_wdata;
  logic [31:0]  lcc_wdata_out;
  awuser_sel_e  awuser_sel;
  zeroize_ovr_e zeroize_ovr;
  logic         fc_esc;
  logic         lc_esc0;
  logic         lc_esc1;
  logic         sva_disable;
  logic         sub_rst_b;
  clk_freq_e    clk_sel;
  logic         clk_switch_req;

  row_t         stim_q[$];
  bit           rows_loaded;
  int           err_cnt;
  int           fail_tests;
  int           low_cycles;
  int           pulse_cnt;

  fc_lcc_svc_top u_fc_lcc_svc_top (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .svc_cmd_valid_i  (svc_cmd_valid),
    .svc_cmd_i        (svc_cmd),
    .clk_byp_ack_i    (clk_byp_ack),
    .fc_wr_i          (fc_wr),
    .fc_addr_i        (fc_addr),
    .fc_wdata_i       (fc_wdata),
    .fc_wdata_o       (fc_wdata_out),
    .lcc_wr_i         (lcc_wr),
    .lcc_addr_i       (lcc_addr),
    .lcc_wdata_i      (lcc_wdata),
    .lcc_wdata_o      (lcc_wdata_out),
    .awuser_sel_o     (awuser_sel),
    .zeroize_ovr_o    (zeroize_ovr),
    .fc_esc_o         (fc_esc),
    .lc_esc0_o        (lc_esc0),
    .lc_esc1_o        (lc_esc1),
    .sva_disable_o    (sva_disable),
    .sub_rst_b_o      (sub_rst_b),
    .clk_sel_o        (clk_sel),
    .clk_switch_req_o (clk_switch_req)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic awuser_check(input string name, input awuser_sel_e got, input awuser_sel_e exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic zeroize_check(input string name, input zeroize_ovr_e got,
                               input zeroize_ovr_e exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic freq_check(input string name, input clk_freq_e got, input clk_freq_e exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic bit_check(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic data_check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // ----------------------------------------------------------------------
  // table helpers
  // ----------------------------------------------------------------------
  task automatic add_row(input svc_cmd_e cmd, input logic [5:0] stim, input awuser_sel_e awuser,
                         input zeroize_ovr_e zeroize, input logic [7:0] bits,
                         input clk_freq_e freq);
    row_t r;
    r.cmd     = cmd;
    r.stim    = stim;
    r.awuser  = awuser;
    r.zeroize = zeroize;
    r.bits    = bits;
    r.freq    = freq;
    stim_q.push_back(r);
  endtask

  // target address on a hit or a random address that misses it
  function automatic logic [31:0] pick_addr(input logic hit, input logic [31:0] target);
    logic [31:0] a;
    a = $urandom;
    if (hit) begin
      a = target;
    end else if (a == target) begin
      a = ~a;
    end
    return a;
  endfunction

  // sub-reset low time measured at every falling edge
  always @(negedge clk) begin
    if (cptra_rst_b) begin
      if (!sub_rst_b) begin
        low_cycles++;
      end else if (low_cycles != 0) begin
        data_check("sub_rst_b_o low cycles", low_cycles, RST_HOLD_CYCLES);
        pulse_cnt++;
        low_cycles = 0;
      end
    end
  end

  // watchdog allows 40 cycles per row plus reset
  initial begin
    wait (rows_loaded);
    #((stim_q.size() * 40 + 10) * 10);
    $display("watchdog expired before the stimulus table finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    row_t r;
    int   i;
    int   errs_before;
    void'($urandom(32'h6a75));
    err_cnt       = 0;
    fail_tests    = 0;
    low_cycles    = 0;
    pulse_cnt     = 0;
    cptra_rst_b   = 1'b0;
    svc_cmd_valid = 1'b0;
    svc_cmd       = RELEASE_AWUSER;
    clk_byp_ack   = 1'b0;
    fc_wr         = 1'b0;
    fc_addr       = '0;
    fc_wdata      = '0;
    lcc_wr        = 1'b0;
    lcc_addr      = '0;
    lcc_wdata     = '0;

    // reset values, awuser and zeroize overrides, unknown opcodes
    add_row(RELEASE_AWUSER, 6'b000000, AWUSER_NONE, ZEROIZE_NONE, 8'b00001000, CLK_F1000);
    add_row(FORCE_AWUSER_CORE, 6'b100000, AWUSER_CORE, ZEROIZE_NONE, 8'b00001000, CLK_F1000);
    add_row(FORCE_AWUSER_MCU, 6'b100000, AWUSER_MCU, ZEROIZE_NONE, 8'b00001000, CLK_F1000);
    add_row(svc_cmd_e'(8'h5a), 6'b100000, AWUSER_MCU, ZEROIZE_NONE, 8'b00001000, CLK_F1000);
    add_row(RELEASE_AWUSER, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b00001000, CLK_F1000);
    add_row(ZEROIZE_SET, 6'b100000, AWUSER_NONE, ZEROIZE_ON, 8'b00001000, CLK_F1000);
    add_row(ZEROIZE_CLEAR, 6'b100000, AWUSER_NONE, ZEROIZE_OFF, 8'b00001000, CLK_F1000);
    add_row(RELEASE_ZEROIZE, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b00001000, CLK_F1000);
    // escalations and the assertion gate plus a command without valid
    add_row(LC_ESC0_SET, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b01001000, CLK_F1000);
    add_row(LC_ESC1_SET, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b01101000, CLK_F1000);
    add_row(LC_ESC0_REL, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b00101000, CLK_F1000);
    add_row(LC_ESC1_REL, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b00001000, CLK_F1000);
    add_row(SVA_DISABLE, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b00011000, CLK_F1000);
    add_row(SVA_ENABLE, 6'b000000, AWUSER_NONE, ZEROIZE_NONE, 8'b00011000, CLK_F1000);
    add_row(SVA_ENABLE, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b00001000, CLK_F1000);
    add_row(FC_ESCALATE, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b10001000, CLK_F1000);
    add_row(svc_cmd_e'(8'hff), 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b10001000, CLK_F1000);
    // sub-reset hold with a second command inside the hold
    add_row(FC_LCC_RESET, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b10000000, CLK_F1000);
    add_row(FC_LCC_RESET, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b10000000, CLK_F1000);
    // clock requests while the hold runs out
    add_row(CLK_400, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b10000000, CLK_F400);
    add_row(CLK_400, 6'b000000, AWUSER_NONE, ZEROIZE_NONE, 8'b10000000, CLK_F400);
    add_row(CLK_500, 6'b110000, AWUSER_NONE, ZEROIZE_NONE, 8'b10000100, CLK_F500);
    add_row(CLK_500, 6'b010000, AWUSER_NONE, ZEROIZE_NONE, 8'b10000000, CLK_F500);
    add_row(CLK_500, 6'b000000, AWUSER_NONE, ZEROIZE_NONE, 8'b10001000, CLK_F500);
    add_row(CLK_1000, 6'b100000, AWUSER_NONE, ZEROIZE_NONE, 8'b10001000, CLK_F1000);
    add_row(CLK_160, 6'b110000, AWUSER_NONE, ZEROIZE_NONE, 8'b10001100, CLK_F160);
    add_row(CLK_160, 6'b000000, AWUSER_NONE, ZEROIZE_NONE, 8'b10001000, CLK_F160);
    add_row(CLK_160, 6'b010000, AWUSER_NONE, ZEROIZE_NONE, 8'b10001000, CLK_F160);
    // bus faults clear bit 0 only on armed writes to the target
    add_row(RELEASE_AWUSER, 6'b001111, AWUSER_NONE, ZEROIZE_NONE, 8'b10001000, CLK_F160);
    add_row(FC_BUS_FAULT, 6'b101111, AWUSER_NONE, ZEROIZE_NONE, 8'b10001010, CLK_F160);
    add_row(FC_BUS_FAULT, 6'b000111, AWUSER_NONE, ZEROIZE_NONE, 8'b10001000, CLK_F160);
    add_row(FC_BUS_FAULT, 6'b001010, AWUSER_NONE, ZEROIZE_NONE, 8'b10001000, CLK_F160);
    add_row(LCC_BUS_FAULT, 6'b101111, AWUSER_NONE, ZEROIZE_NONE, 8'b10001011, CLK_F160);
    add_row(LCC_BUS_FAULT, 6'b001101, AWUSER_NONE, ZEROIZE_NONE, 8'b10001010, CLK_F160);
    add_row(LCC_BUS_FAULT, 6'b000011, AWUSER_NONE, ZEROIZE_NONE, 8'b10001001, CLK_F160);
    add_row(LCC_BUS_FAULT, 6'b001000, AWUSER_NONE, ZEROIZE_NONE, 8'b10001000, CLK_F160);
    add_row(svc_cmd_e'(8'h33), 6'b101111, AWUSER_NONE, ZEROIZE_NONE, 8'b10001011, CLK_F160);
    rows_loaded = 1'b1;

    repeat (10) @(posedge clk);
    cptra_rst_b <= 1'b1;

    for (i = 0; i < stim_q.size(); i++) begin
      r = stim_q[i];
      errs_before = err_cnt;
      @(posedge clk);
      svc_cmd_valid <= r.stim[5];
      svc_cmd       <= r.cmd;
      clk_byp_ack   <= r.stim[4];
      fc_wr         <= r.stim[3];
      fc_addr       <= pick_addr(r.stim[2], FC_FAULT_ADDR);
      fc_wdata      <= $urandom | 32'h1;
      lcc_wr        <= r.stim[1];
      lcc_addr      <= pick_addr(r.stim[0], LCC_FAULT_ADDR);
      lcc_wdata     <= $urandom | 32'h1;
      // command taken on this edge while bus and ack hold
      @(posedge clk);
      svc_cmd_valid <= 1'b0;
      @(negedge clk);
      awuser_check("awuser_sel_o", awuser_sel, r.awuser);
      zeroize_check("zeroize_ovr_o", zeroize_ovr, r.zeroize);
      freq_check("clk_sel_o", clk_sel, r.freq);
      bit_check("fc_esc_o", fc_esc, r.bits[7]);
      bit_check("lc_esc0_o", lc_esc0, r.bits[6]);
      bit_check("lc_esc1_o", lc_esc1, r.bits[5]);
      bit_check("sva_disable_o", sva_disable, r.bits[4]);
      bit_check("sub_rst_b_o", sub_rst_b, r.bits[3]);
      bit_check("clk_switch_req_o", clk_switch_req, r.bits[2]);
      data_check("fc_wdata_o", fc_wdata_out, fc_wdata & ~{31'b0, r.bits[1]});
      data_check("lcc_wdata_o", lcc_wdata_out, lcc_wdata & ~{31'b0, r.bits[0]});
      if (err_cnt != errs_before) begin
        fail_tests++;
      end
      $display("test %0d cmd %h valid %b %s", i + 1, r.cmd, r.stim[5],
               (err_cnt == errs_before) ? "ok" : "FAILED");
    end

    // exactly one hold window despite the second reset command
    data_check("sub_rst_b_o pulse count", pulse_cnt, 32'd1);
    $display("tests %0d, failed %0d, errors %0d", stim_q.size(), fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
source/fc_lcc_svc_pkg.sv
source/svc_override_regs.sv
source/svc_reset_pulser.sv
source/svc_clk_req.sv
source/svc_bus_fault.sv
source/fc_lcc_svc_top.sv
testbench/tb_fc_lcc_svc.sv
